//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = vision_tb
FILELIST  = vision_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/vision_props.sv
//--------------------------------------
// concurrent checks on the vision_top ports,
// attached by bind
//--------------------------------------
`timescale 1ns/1ns

module vision_props (
	input logic clk_llc,
	input logic resetx,
	input logic frame_irq,
	input logic host_rd,
	input logic host_rvalid
);

	irq_one_cycle: assert property (@(posedge clk_llc) disable iff (!resetx)
		frame_irq |=> !frame_irq)
		else $error("frame_irq high for more than one cycle");

	// read data exactly one cycle after the strobe
	rvalid_after_rd: assert property (@(posedge clk_llc) disable iff (!resetx)
		host_rd |=> host_rvalid)
		else $error("host_rvalid missing one cycle after host_rd");

	rvalid_needs_rd: assert property (@(posedge clk_llc) disable iff (!resetx)
		host_rvalid |-> $past(host_rd))
		else $error("host_rvalid without a host_rd the cycle before");

endmodule

bind vision_top vision_props u_props (
	.clk_llc(clk_llc), .resetx(resetx), .frame_irq(frame_irq),
	.host_rd(host_rd), .host_rvalid(host_rvalid)
);

//--- bench/vision_model.svh
//--------------------------------------
// reference model of the vision pipeline.
// included into the testbench module, gives
// decode, hsv, classify and group mask
//--------------------------------------
`ifndef VISION_MODEL_SVH
`define VISION_MODEL_SVH

// saturate to one byte
function automatic logic [7:0] sat_byte(input int v);
	if (v < 0)
		return 8'd0;
	if (v > 255)
		return 8'd255;
	return 8'(v);
endfunction

function automatic vision_pkg::rgb_t decode_pixel(input logic [7:0] y, cb, cr);
	int ys, us, vs;
	vision_pkg::rgb_t c;
	ys = int'(y) - 16;
	us = int'(cb) - 128;
	vs = int'(cr) - 128;
	c.r = sat_byte((ys * 298 + vs * 409) >>> 8);
	c.g = sat_byte((ys * 298 - vs * 208 - us * 100) >>> 8);
	c.b = sat_byte((ys * 298 + us * 516) >>> 8);
	return c;
endfunction

function automatic vision_pkg::hsv_t to_hsv(input vision_pkg::rgb_t c);
	int r, g, b, mx, mn, diff, base;
	vision_pkg::hsv_t p;
	r = int'(c.r);
	g = int'(c.g);
	b = int'(c.b);
	if (r >= g && r >= b)
	begin
		mx = r;
		diff = g - b;
		base = 240;                     // red wraps around the circle
	end
	else if (g >= b)
	begin
		mx = g;
		diff = b - r;
		base = 80;
	end
	else
	begin
		mx = b;
		diff = r - g;
		base = 160;
	end
	mn = r;
	if (g < mn)
		mn = g;
	if (b < mn)
		mn = b;
	p.v = 8'(mx);
	p.s = (mx == 0) ? 8'd0 : 8'((mx - mn) * 255 / mx);
	p.h = (mx == mn) ? 8'd0 : 8'((diff * 40 / (mx - mn) + base) % 240);
	return p;
endfunction

// open window, bounds wrap in 8 bits
function automatic logic hue_in_window(input logic [7:0] centre, tol, h);
	logic [7:0] lo, hi;
	lo = centre - tol;
	hi = centre + tol;
	return (h > lo) && (h < hi);
endfunction

function automatic vision_pkg::class_t classify(input vision_pkg::hsv_t p,
	input vision_pkg::class_cfg_t c);
	vision_pkg::class_t k;
	logic vivid;
	k.black  = p.v < c.v_thres;
	vivid    = !k.black && (p.s > c.s_thres);
	k.red    = vivid && hue_in_window(c.red, c.hue_tol, p.h);
	k.orange = vivid && hue_in_window(c.orange, c.hue_tol, p.h);
	k.yellow = vivid && hue_in_window(c.yellow, c.hue_tol, p.h);
	k.green  = vivid && hue_in_window(c.green, c.hue_tol, p.h);
	k.blue   = vivid && hue_in_window(c.blue, c.hue_tol, p.h);
	return k;
endfunction

function automatic logic [15:0] group_mask(input vision_pkg::class_t k);
	logic [15:0] m;
	m[15]  = k.red | k.orange | k.yellow;
	m[14]  = m[15] | k.black;
	m[13]  = k.red;
	m[12]  = k.orange;
	m[11]  = k.yellow;
	m[10]  = k.green | k.yellow;
	m[9]   = m[10] | k.orange | k.black;
	m[8]   = m[10] | k.orange;
	m[7:5] = {3{k.green}};
	m[4]   = k.blue;
	m[3]   = k.blue | k.black;
	m[2:1] = {2{k.blue}};
	m[0]   = k.black;
	return m;
endfunction

`endif

//--- bench/vision_tb.sv
//--------------------------------------
// testbench for vision_top. random frames,
// host readback of both banks against the
// model, config change, overlong frame
//--------------------------------------
`timescale 1ns/1ns

module vision_tb;

	localparam int IMG_W  = 16;
	localparam int IMG_H  = 8;
	localparam int PIX_N  = IMG_W * IMG_H;
	localparam int ADDR_W = $clog2(PIX_N);
	localparam int CLK_NS = 100;
	localparam int FRAMES = 4;
	localparam int READ_PASSES = 7;
	// frames, bank readbacks, then reset and config slack
	localparam int WATCHDOG_NS = FRAMES * (2 * PIX_N + 200) * CLK_NS
		+ READ_PASSES * (PIX_N + 20) * CLK_NS + 100 * CLK_NS;

	// palette, saturated colours and darks
	localparam int PAL_Y  [7] = '{82, 146, 210, 145, 41, 24, 40};
	localparam int PAL_CB [7] = '{90, 53, 16, 54, 236, 126, 110};
	localparam int PAL_CR [7] = '{236, 193, 146, 34, 110, 126, 170};

	logic clk_llc, resetx;
	logic vref, href;
	logic [7:0] vpo;
	logic cfg_wr;
	logic [2:0] cfg_addr;
	logic [7:0] cfg_wdata;
	logic host_rd, host_rd_bank;
	logic [ADDR_W-1:0] host_addr;
	logic [15:0] host_rdata;
	logic host_rvalid, frame_irq, frame_bank;

	logic [15:0] exp_mask [2][PIX_N];   // expected masks per bank
	vision_pkg::class_cfg_t model_cfg;

	`include "vision_model.svh"

	vision_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) UUT (
		.clk_llc(clk_llc), .resetx(resetx), .vref(vref), .href(href), .vpo(vpo),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.host_rd(host_rd), .host_rd_bank(host_rd_bank), .host_addr(host_addr),
		.host_rdata(host_rdata), .host_rvalid(host_rvalid),
		.frame_irq(frame_irq), .frame_bank(frame_bank)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #(CLK_NS / 2) clk_llc = ~clk_llc;
	end

	//--------------------------------------
	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1);
	endtask

	// one cycle, nothing may fire mid-frame
	task automatic quiet_cycle();
		@(negedge clk_llc);
		assert (frame_irq == 1'b0)
			else fail_now($sformatf("[ERROR] frame_irq = %h, expected %h", frame_irq, 1'b0));
		assert (host_rvalid == 1'b0)
			else fail_now($sformatf("[ERROR] host_rvalid = %h, expected %h", host_rvalid, 1'b0));
	endtask

	task automatic pick_group(output logic [7:0] cb, y0, cr, y1);
		int idx;
		idx = $urandom_range(6, 0);
		if ($urandom_range(1, 0) == 0)
		begin
			cb = 8'($urandom);              // fully random group
			y0 = 8'($urandom);
			cr = 8'($urandom);
			y1 = 8'($urandom);
		end
		else
		begin
			cb = 8'(PAL_CB[idx] + $urandom_range(6, 0));
			cr = 8'(PAL_CR[idx] + $urandom_range(6, 0));
			y0 = 8'(PAL_Y[idx] + $urandom_range(10, 0));
			y1 = 8'(PAL_Y[idx] + $urandom_range(10, 0));
		end
	endtask

	task automatic record_pixel(input logic bank, input int p, input logic [7:0] y, cb, cr);
		if (p < PIX_N)                      // overflow pixels are never stored
			exp_mask[bank][p] = group_mask(classify(to_hsv(decode_pixel(y, cb, cr)), model_cfg));
	endtask

	//--------------------------------------
	task automatic send_frame(input logic bank, input int lines);
		logic [7:0] grp [4];               // Cb Y0 Cr Y1
		int p;
		p = 0;
		quiet_cycle();
		vref = 1'b1;
		repeat (2) quiet_cycle();
		for (int ln = 0; ln < lines; ln++)
		begin
			for (int g = 0; g < IMG_W / 2; g++)
			begin
				pick_group(grp[0], grp[1], grp[2], grp[3]);
				record_pixel(bank, p, grp[1], grp[0], grp[2]);
				record_pixel(bank, p + 1, grp[3], grp[0], grp[2]);
				p += 2;
				for (int k = 0; k < 4; k++)
				begin
					quiet_cycle();
					href = 1'b1;
					vpo = grp[k];
				end
			end
			quiet_cycle();
			href = 1'b0;                    // line gap, phase restarts
			vpo = 8'h00;
			repeat (3) quiet_cycle();
		end
		repeat (12) quiet_cycle();          // drain the pipeline
		vref = 1'b0;
	endtask

	task automatic wait_frame_irq(input logic bank);
		int n;
		n = 0;
		@(negedge clk_llc);
		while (frame_irq !== 1'b1 && n < 20)
		begin
			@(negedge clk_llc);
			n++;
		end
		assert (frame_irq === 1'b1) else fail_now("frame_irq never came after vref fell");
		assert (frame_bank == bank)
			else fail_now($sformatf("[ERROR] frame_bank = %h, expected %h", frame_bank, bank));
		@(negedge clk_llc);
		assert (frame_irq == 1'b0) else fail_now("frame_irq lasted more than one cycle");
	endtask

	// back to back reads, data one cycle behind
	task automatic check_bank(input logic bank);
		for (int i = 0; i <= PIX_N; i++)
		begin
			@(negedge clk_llc);
			if (i > 0)
			begin
				assert (host_rvalid === 1'b1)
					else fail_now($sformatf("[ERROR] host_rvalid = %h, expected %h", host_rvalid, 1'b1));
				assert (host_rdata === exp_mask[bank][i-1])
					else fail_now($sformatf("[ERROR] host_rdata bank %h addr %h = %h, expected %h",
						bank, i - 1, host_rdata, exp_mask[bank][i-1]));
			end
			host_rd = (i < PIX_N);
			host_rd_bank = bank;
			host_addr = ADDR_W'(i);
		end
		@(negedge clk_llc);
		assert (host_rvalid == 1'b0) else fail_now("host_rvalid stayed high with no read");
	endtask

	task automatic write_cfg(input logic [2:0] addr, input logic [7:0] data);
		@(negedge clk_llc);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(negedge clk_llc);
		cfg_wr = 1'b0;
		case (addr)
			3'd0: model_cfg.red = data;
			3'd1: model_cfg.orange = data;
			3'd2: model_cfg.yellow = data;
			3'd3: model_cfg.green = data;
			3'd4: model_cfg.blue = data;
			3'd5: model_cfg.hue_tol = data;
			3'd6: model_cfg.s_thres = data;
			default: model_cfg.v_thres = data;
		endcase
	endtask

	task automatic load_new_config();
		write_cfg(3'd0, 8'($urandom_range(239, 200)));   // red near the wrap
		write_cfg(3'd1, 8'($urandom_range(30, 5)));
		write_cfg(3'd2, 8'($urandom_range(60, 30)));
		write_cfg(3'd3, 8'($urandom_range(110, 70)));
		write_cfg(3'd4, 8'($urandom_range(170, 130)));
		write_cfg(3'd5, 8'($urandom_range(20, 6)));
		write_cfg(3'd6, 8'($urandom_range(120, 40)));
		write_cfg(3'd7, 8'($urandom_range(100, 30)));
	endtask

	//--------------------------------------
	initial
	begin
		#(WATCHDOG_NS);
		fail_now("watchdog expired, the run took too long");
	end

	initial
	begin
		void'($urandom(32'h4ef1));
		resetx = 1'b0;
		vref = 1'b0;
		href = 1'b0;
		vpo = 8'h00;
		cfg_wr = 1'b0;
		cfg_addr = 3'd0;
		cfg_wdata = 8'h00;
		host_rd = 1'b0;
		host_rd_bank = 1'b0;
		host_addr = '0;
		model_cfg = '{red: 8'd230, orange: 8'd15, yellow: 8'd40, green: 8'd90,
			blue: 8'd144, hue_tol: 8'd10, s_thres: 8'd96, v_thres: 8'd96};
		repeat (10) @(negedge clk_llc);
		resetx = 1'b1;
		repeat (5) quiet_cycle();          // idle after reset
		send_frame(1'b0, IMG_H);
		wait_frame_irq(1'b0);
		check_bank(1'b0);
		send_frame(1'b1, IMG_H);           // second bank, first kept
		wait_frame_irq(1'b1);
		check_bank(1'b0);
		check_bank(1'b1);
		load_new_config();
		send_frame(1'b0, IMG_H);
		wait_frame_irq(1'b0);
		check_bank(1'b0);
		check_bank(1'b1);
		send_frame(1'b1, IMG_H + 1);       // one line too many
		wait_frame_irq(1'b1);
		check_bank(1'b0);
		check_bank(1'b1);
		$display("Everything OK");
		$finish;
	end

endmodule

//--- color/class_config.sv
//--------------------------------------
// host registers for the classifier. one
// byte per address, cfg_wr strobe writes
//--------------------------------------
`timescale 1ns/1ns

module class_config (
	input  logic                                clk_llc,
	input  logic                                resetx,
	input  logic                                cfg_wr,
	input  logic [vision_pkg::CFG_ADDR_W-1:0]   cfg_addr,
	input  logic [7:0]                          cfg_wdata,
	output vision_pkg::class_cfg_t              cfg
);

	// 0..4 hue centres, 5 tolerance, 6/7 s and v thresholds
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			cfg <= vision_pkg::CFG_RESET;
		else if (cfg_wr)
			case (cfg_addr)
				3'd0: cfg.red     <= cfg_wdata;
				3'd1: cfg.orange  <= cfg_wdata;
				3'd2: cfg.yellow  <= cfg_wdata;
				3'd3: cfg.green   <= cfg_wdata;
				3'd4: cfg.blue    <= cfg_wdata;
				3'd5: cfg.hue_tol <= cfg_wdata;
				3'd6: cfg.s_thres <= cfg_wdata;
				default: cfg.v_thres <= cfg_wdata;
			endcase

endmodule

//--- color/color_classifier.sv
//--------------------------------------
// HSV pixel to six-bit class word against
// the live configuration, one cycle
//--------------------------------------
`timescale 1ns/1ns

module color_classifier (
	input  logic                   clk_llc,
	input  logic                   resetx,
	input  vision_pkg::hsv_t       hsv,
	input  logic                   hsv_valid,
	input  vision_pkg::class_cfg_t cfg,
	output vision_pkg::class_t     cls,
	output logic                   class_valid
);

	logic black, colourful;

	// open window around centre, 8-bit wrapping bounds
	function automatic logic in_window(input logic [7:0] centre, tol, h);
		logic [7:0] lo, hi;
		lo = centre - tol;
		hi = centre + tol;
		return (lo < h) && (h < hi);
	endfunction

	assign black     = hsv.v < cfg.v_thres;
	assign colourful = !black && (hsv.s > cfg.s_thres);

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			class_valid <= 1'b0;
		else
			class_valid <= hsv_valid;

	always_ff @(posedge clk_llc)
	begin
		cls.black  <= black;
		cls.red    <= colourful && in_window(cfg.red,    cfg.hue_tol, hsv.h);
		cls.orange <= colourful && in_window(cfg.orange, cfg.hue_tol, hsv.h);
		cls.yellow <= colourful && in_window(cfg.yellow, cfg.hue_tol, hsv.h);
		cls.green  <= colourful && in_window(cfg.green,  cfg.hue_tol, hsv.h);
		cls.blue   <= colourful && in_window(cfg.blue,   cfg.hue_tol, hsv.h);
	end

endmodule

//--- color/rgb_to_hsv.sv
//--------------------------------------
// RGB888 to HSV, three pipeline stages.
// hue runs 0..239 in sectors of 40
//--------------------------------------
`timescale 1ns/1ns

module rgb_to_hsv (
	input  logic             clk_llc,
	input  logic             resetx,
	input  vision_pkg::rgb_t rgb,
	input  logic             rgb_valid,
	output vision_pkg::hsv_t hsv,
	output logic             hsv_valid
);

	localparam logic [1:0] CH_R = 2'd0;
	localparam logic [1:0] CH_G = 2'd1;
	localparam logic [1:0] CH_B = 2'd2;
	localparam logic signed [15:0] SEC = 16'(vision_pkg::HUE_SECTOR);

	logic [7:0] mx, mn;
	logic [1:0] mx_ch;
	logic s1_valid, s2_valid;
	logic [7:0] s1_max, s1_min, s2_v, s2_delta;
	logic [1:0] s1_ch, s2_ch;
	vision_pkg::rgb_t s1_rgb;           // stage one copy for the hue difference
	logic signed [8:0] diff, s2_diff;
	logic signed [15:0] num, den, quot, hue;
	logic [15:0] sat;

	//--------------------------------------
	// stage one, max / min / max channel
	always_comb
	begin
		if (rgb.r >= rgb.g && rgb.r >= rgb.b)
		begin
			mx = rgb.r;
			mx_ch = CH_R;
		end
		else if (rgb.g >= rgb.b)
		begin
			mx = rgb.g;
			mx_ch = CH_G;
		end
		else
		begin
			mx = rgb.b;
			mx_ch = CH_B;
		end
		mn = rgb.r;
		if (rgb.g < mn) mn = rgb.g;
		if (rgb.b < mn) mn = rgb.b;
	end

	// stage two, signed difference of the other two channels
	always_comb
		case (s1_ch)
			CH_R: diff = $signed({1'b0, s1_rgb.g}) - $signed({1'b0, s1_rgb.b});
			CH_G: diff = $signed({1'b0, s1_rgb.b}) - $signed({1'b0, s1_rgb.r});
			default: diff = $signed({1'b0, s1_rgb.r}) - $signed({1'b0, s1_rgb.g});
		endcase

	// stage three, the two divides
	assign num  = 16'(s2_diff) * SEC;
	assign den  = (s2_delta == 8'd0) ? 16'sd1 : 16'(s2_delta);
	assign quot = num / den;            // truncates toward zero
	assign sat  = (s2_v == 8'd0) ? 16'd0 : ({s2_delta, 8'd0} - 16'(s2_delta)) / 16'(s2_v);

	always_comb
		case (s2_ch)
			CH_R: hue = (quot < 0) ? quot + 6 * SEC : quot;   // wrap into 0..239
			CH_G: hue = quot + 2 * SEC;
			default: hue = quot + 4 * SEC;
		endcase

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			hsv_valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= rgb_valid;
			s2_valid  <= s1_valid;
			hsv_valid <= s2_valid;
		end

	always_ff @(posedge clk_llc)
	begin
		s1_max   <= mx;
		s1_min   <= mn;
		s1_ch    <= mx_ch;
		s1_rgb   <= rgb;
		s2_v     <= s1_max;
		s2_delta <= s1_max - s1_min;
		s2_diff  <= diff;
		s2_ch    <= s1_ch;
		hsv.h    <= (s2_delta == 8'd0) ? 8'd0 : hue[7:0];   // grey has no hue
		hsv.s    <= sat[7:0];
		hsv.v    <= s2_v;
	end

endmodule

//--- color/ycc_to_rgb.sv
//--------------------------------------
// splits the Cb Y0 Cr Y1 byte stream and
// converts each pixel to RGB888. two pixels
// per byte group, one rgb_valid pulse each
//--------------------------------------
`timescale 1ns/1ns

module ycc_to_rgb (
	input  logic             clk_llc,
	input  logic             resetx,
	input  logic             href,
	input  logic [7:0]       vpo,
	output vision_pkg::rgb_t rgb,
	output logic             rgb_valid
);

	localparam logic signed [19:0] K_Y  = 20'(vision_pkg::COEF_Y);
	localparam logic signed [19:0] K_RV = 20'(vision_pkg::COEF_RV);
	localparam logic signed [19:0] K_GV = 20'(vision_pkg::COEF_GV);
	localparam logic signed [19:0] K_GU = 20'(vision_pkg::COEF_GU);
	localparam logic signed [19:0] K_BU = 20'(vision_pkg::COEF_BU);

	logic [1:0] phase;                  // 0 Cb, 1 Y0, 2 Cr, 3 Y1
	logic [7:0] cb_q, y0_q, cr_q, y1_q;
	logic go0, go1;                     // pixel 0 or 1 ready for products
	vision_pkg::ycc_t pix;
	logic signed [19:0] y_s, cb_s, cr_s;
	logic signed [19:0] p_y, p_rv, p_gv, p_gu, p_bu;
	logic p_valid;
	logic signed [20:0] sum_r, sum_g, sum_b;

	// >>8 then saturate to 0..255
	function automatic logic [7:0] clamp8(input logic signed [20:0] x);
		if (x < 0)
			return 8'd0;
		else if (x[20:16] != 5'd0)
			return 8'hff;
		else
			return x[15:8];
	endfunction

	//--------------------------------------
	// byte phase and latches
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			phase <= 2'd0;
			go0   <= 1'b0;
			go1   <= 1'b0;
		end
		else
		begin
			phase <= href ? phase + 2'd1 : 2'd0;   // restart at Cb
			go0   <= href && (phase == 2'd2);
			go1   <= href && (phase == 2'd3);
		end

	always_ff @(posedge clk_llc)
		if (href)
			case (phase)
				2'd0: cb_q <= vpo;
				2'd1: y0_q <= vpo;
				2'd2: cr_q <= vpo;
				default: y1_q <= vpo;
			endcase

	// both pixels of a group share cb/cr
	assign pix = '{y: go1 ? y1_q : y0_q, cb: cb_q, cr: cr_q};

	assign y_s  = 20'(pix.y)  - 20'(vision_pkg::Y_OFFSET);
	assign cb_s = 20'(pix.cb) - 20'(vision_pkg::C_OFFSET);
	assign cr_s = 20'(pix.cr) - 20'(vision_pkg::C_OFFSET);

	//--------------------------------------
	// stage one, signed products
	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			p_valid <= 1'b0;
		else
			p_valid <= go0 | go1;

	always_ff @(posedge clk_llc)
	begin
		p_y  <= y_s * K_Y;
		p_rv <= cr_s * K_RV;
		p_gv <= cr_s * K_GV;
		p_gu <= cb_s * K_GU;
		p_bu <= cb_s * K_BU;
	end

	// stage two, sum and clamp
	assign sum_r = 21'(p_y) + 21'(p_rv);
	assign sum_g = 21'(p_y) - 21'(p_gv) - 21'(p_gu);
	assign sum_b = 21'(p_y) + 21'(p_bu);

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= p_valid;

	always_ff @(posedge clk_llc)
	begin
		rgb.r <= clamp8(sum_r);
		rgb.g <= clamp8(sum_g);
		rgb.b <= clamp8(sum_b);
	end

endmodule

//--- common/vision_pkg.sv
//--------------------------------------
// shared types and constants of the colour
// vision pipeline. modules refer to them by
// scoped names, vision_pkg::name
//--------------------------------------

package vision_pkg;

	localparam int PIX_W = 8;          // channel width, colour and hsv

	// one decoded 4:2:2 sample set for a pixel
	typedef struct packed {
		logic [PIX_W-1:0] y;
		logic [PIX_W-1:0] cb;
		logic [PIX_W-1:0] cr;
	} ycc_t;

	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		logic [PIX_W-1:0] h;            // 0..239
		logic [PIX_W-1:0] s;
		logic [PIX_W-1:0] v;
	} hsv_t;

	// class word, red is the msb
	typedef struct packed {
		logic red;
		logic orange;
		logic yellow;
		logic green;
		logic blue;
		logic black;
	} class_t;

	//--------------------------------------
	// classifier configuration, byte per field
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] orange;
		logic [7:0] yellow;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] hue_tol;
		logic [7:0] s_thres;
		logic [7:0] v_thres;
	} class_cfg_t;

	// ycc to rgb, 8.8 fixed point
	localparam logic [9:0] COEF_Y  = 10'd298;    // 1.164
	localparam logic [9:0] COEF_RV = 10'd409;    // 1.596
	localparam logic [9:0] COEF_GV = 10'd208;    // 0.813
	localparam logic [9:0] COEF_GU = 10'd100;    // 0.392
	localparam logic [9:0] COEF_BU = 10'd516;    // 2.017

	localparam logic [7:0] Y_OFFSET = 8'd16;
	localparam logic [7:0] C_OFFSET = 8'd128;

	localparam logic [7:0] HUE_SECTOR = 8'd40;  // six sectors, circle of 240

	localparam class_cfg_t CFG_RESET = '{
		red: 8'd230, orange: 8'd15, yellow: 8'd40, green: 8'd90, blue: 8'd144,
		hue_tol: 8'd10, s_thres: 8'd96, v_thres: 8'd96
	};

	localparam int CFG_ADDR_W = 3;
	localparam int MASK_W = 16;        // host group mask

endpackage

//--- frame/frame_buffer.sv
//--------------------------------------
// two banks of class words. video writes
// one side, host reads the other with one
// cycle latency as a 16-bit group mask
//--------------------------------------
`timescale 1ns/1ns

module frame_buffer #(
	parameter int IMG_W = 180,
	parameter int IMG_H = 120,
	localparam int ADDR_W = $clog2(IMG_W * IMG_H)
) (
	input  logic                          clk_llc,
	input  logic                          wr_en,
	input  logic                          wr_bank,
	input  logic [ADDR_W-1:0]             wr_addr,
	input  vision_pkg::class_t            cls,
	input  logic                          host_rd,
	input  logic                          host_rd_bank,
	input  logic [ADDR_W-1:0]             host_addr,
	output logic [vision_pkg::MASK_W-1:0] host_rdata,
	output logic                          host_rvalid
);

	localparam int DEPTH = IMG_W * IMG_H;

	vision_pkg::class_t ram [2][DEPTH];
	vision_pkg::class_t wr_word;        // cls delayed to line up with wr_en
	vision_pkg::class_t rd_word;
	logic roy, roybk, gy, gyo, gyobk, bbk;

	always_ff @(posedge clk_llc)
	begin
		wr_word <= cls;
		if (wr_en)
			ram[wr_bank][wr_addr] <= wr_word;
		if (host_rd)
			rd_word <= ram[host_rd_bank][host_addr];
		host_rvalid <= host_rd;
	end

	//--------------------------------------
	// group mask expansion
	assign roy   = rd_word.red | rd_word.orange | rd_word.yellow;
	assign roybk = roy | rd_word.black;
	assign gy    = rd_word.green | rd_word.yellow;
	assign gyo   = gy | rd_word.orange;
	assign gyobk = gyo | rd_word.black;
	assign bbk   = rd_word.blue | rd_word.black;

	assign host_rdata = {roy, roybk, rd_word.red, rd_word.orange, rd_word.yellow,
		gy, gyobk, gyo, {3{rd_word.green}},
		rd_word.blue, bbk, {2{rd_word.blue}}, rd_word.black};

endmodule

//--- frame/frame_writer.sv
//--------------------------------------
// pixel address counter for the class map.
// swaps bank and raises frame_irq at the
// falling edge of vref
//--------------------------------------
`timescale 1ns/1ns

module frame_writer #(
	parameter int IMG_W = 180,
	parameter int IMG_H = 120,
	localparam int ADDR_W = $clog2(IMG_W * IMG_H)
) (
	input  logic              clk_llc,
	input  logic              resetx,
	input  logic              vref,
	input  logic              class_valid,
	output logic              wr_en,
	output logic              wr_bank,
	output logic [ADDR_W-1:0] wr_addr,
	output logic              frame_irq,
	output logic              frame_bank
);

	localparam int PIX_N = IMG_W * IMG_H;
	localparam int CNT_W = $clog2(PIX_N + 1);   // room to hold PIX_N itself

	logic [CNT_W-1:0] pix_cnt;
	logic vref_d;
	logic frame_end;

	assign frame_end = vref_d & ~vref;

	always_ff @(posedge clk_llc or negedge resetx)
		if (!resetx)
		begin
			vref_d     <= 1'b0;
			wr_en      <= 1'b0;
			wr_bank    <= 1'b0;         // first frame into bank 0
			frame_irq  <= 1'b0;
			frame_bank <= 1'b0;
			pix_cnt    <= '0;
		end
		else
		begin
			vref_d    <= vref;
			frame_irq <= frame_end;
			wr_en     <= class_valid && (pix_cnt < CNT_W'(PIX_N));   // drop overflow
			if (frame_end)
			begin
				frame_bank <= wr_bank;   // report the finished bank
				wr_bank    <= ~wr_bank;
				pix_cnt    <= '0;
			end
			else if (class_valid && pix_cnt != CNT_W'(PIX_N))
				pix_cnt <= pix_cnt + 1'b1;  // saturates, no wrap
		end

	always_ff @(posedge clk_llc)
		if (class_valid)
			wr_addr <= pix_cnt[ADDR_W-1:0];

endmodule

//--- source/vision_top.sv
//--------------------------------------
// colour vision top level. video bytes in,
// class map in a double buffer out to the
// host, frame_irq per completed frame
//--------------------------------------
`timescale 1ns/1ns

module vision_top #(
	parameter int IMG_W = 180,
	parameter int IMG_H = 120,
	localparam int ADDR_W = $clog2(IMG_W * IMG_H)
) (
	input  logic                              clk_llc,
	input  logic                              resetx,
	// video decoder side
	input  logic                              vref,
	input  logic                              href,
	input  logic [7:0]                        vpo,
	// configuration registers
	input  logic                              cfg_wr,
	input  logic [vision_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [7:0]                        cfg_wdata,
	// host reads
	input  logic                              host_rd,
	input  logic                              host_rd_bank,
	input  logic [ADDR_W-1:0]                 host_addr,
	output logic [vision_pkg::MASK_W-1:0]     host_rdata,
	output logic                              host_rvalid,
	output logic                              frame_irq,
	output logic                              frame_bank
);

	vision_pkg::rgb_t       rgb;
	vision_pkg::hsv_t       hsv;
	vision_pkg::class_cfg_t cfg;
	vision_pkg::class_t     cls;
	logic rgb_valid, hsv_valid, class_valid;
	logic wr_en, wr_bank;
	logic [ADDR_W-1:0] wr_addr;

	//--------------------------------------
	// colour path, 2 + 3 + 1 cycles
	ycc_to_rgb u_ycc (
		.clk_llc(clk_llc), .resetx(resetx), .href(href), .vpo(vpo),
		.rgb(rgb), .rgb_valid(rgb_valid)
	);

	rgb_to_hsv u_hsv (
		.clk_llc(clk_llc), .resetx(resetx), .rgb(rgb), .rgb_valid(rgb_valid),
		.hsv(hsv), .hsv_valid(hsv_valid)
	);

	class_config u_cfg (
		.clk_llc(clk_llc), .resetx(resetx), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg(cfg)
	);

	color_classifier u_cls (
		.clk_llc(clk_llc), .resetx(resetx), .hsv(hsv), .hsv_valid(hsv_valid),
		.cfg(cfg), .cls(cls), .class_valid(class_valid)
	);

	// frame storage
	frame_writer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_wr (
		.clk_llc(clk_llc), .resetx(resetx), .vref(vref), .class_valid(class_valid),
		.wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
		.frame_irq(frame_irq), .frame_bank(frame_bank)
	);

	frame_buffer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_buf (
		.clk_llc(clk_llc), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
		.cls(cls), .host_rd(host_rd), .host_rd_bank(host_rd_bank),
		.host_addr(host_addr), .host_rdata(host_rdata), .host_rvalid(host_rvalid)
	);

endmodule

//--- vision_top.f
+incdir+bench
common/vision_pkg.sv
color/ycc_to_rgb.sv
color/rgb_to_hsv.sv
color/class_config.sv
color/color_classifier.sv
frame/frame_writer.sv
frame/frame_buffer.sv
source/vision_top.sv
bench/vision_props.sv
bench/vision_tb.sv
